// ==== all.f ====
logic/mips_pkg.sv
logic/instr_decode.sv
logic/hazard_unit.sv
logic/reg_file.sv
logic/exec_alu.sv
logic/data_ram.sv
logic/pipe_core.sv
sim/pipe_core_tb.sv

// ==== logic/data_ram.sv ====
`timescale 1ns/1ns
module data_ram (
	input logic clk,
	input logic [31:0] addr,
	input logic we,
	input logic [31:0] wd,
	output logic [31:0] rd
);
	logic [31:0] mem [0:63];
	logic [5:0] word;

	// Byte address in, word index out
	// Upper bits wrap onto the 64 words
	assign word = addr[7:2];

	// Write on the edge
	always_ff @(posedge clk) begin
		if (we)
			mem[word] <= wd;
	end

	// Combinational read
	assign rd = mem[word];

endmodule

// ==== logic/exec_alu.sv ====
`timescale 1ns/1ns
module exec_alu (
	input mips_pkg::alu_op_t alu_op,
	input logic [31:0] a,
	input logic [31:0] b,
	output logic [31:0] y
);

	// Wraparound arithmetic with no overflow trap
	// Address generation for lw and sw uses the add path
	always_comb begin
		case (alu_op)
			mips_pkg::alu_add: begin
				y = a + b;
			end
			mips_pkg::alu_sub: begin
				y = a - b;
			end
			mips_pkg::alu_or: begin
				// ori operand comes in zero extended
				y = a | b;
			end
			default: begin
				// Unused code behaves as add
				y = a + b;
			end
		endcase
	end

endmodule

// ==== logic/hazard_unit.sv ====
`timescale 1ns/1ns
module hazard_unit (
	input logic [4:0] d_rs,
	input logic [4:0] d_rt,
	input logic [1:0] t_use_rs,
	input logic [1:0] t_use_rt,
	input logic [4:0] e_wreg,
	input logic e_we,
	input logic [1:0] e_t_new,
	input logic [4:0] m_wreg,
	input logic m_we,
	input logic [1:0] m_t_new,
	input logic [4:0] w_wreg,
	input logic w_we,
	input logic [4:0] e_rs,
	input logic [4:0] e_rt,
	input logic [4:0] m_rt,
	output logic stall,
	output mips_pkg::fwd_sel_t d_rs_sel,
	output mips_pkg::fwd_sel_t d_rt_sel,
	output mips_pkg::fwd_sel_t e_rs_sel,
	output mips_pkg::fwd_sel_t e_rt_sel,
	output mips_pkg::fwd_sel_t m_rt_sel
);
	logic e_hit_rs;
	logic e_hit_rt;
	logic m_hit_rs;
	logic m_hit_rt;
	logic m_ready;

	// Nearest older producer wins and memory comes before writeback
	function automatic mips_pkg::fwd_sel_t pick(input logic [4:0] src, input logic mem_en,
		input logic [4:0] mem_dst, input logic wb_en, input logic [4:0] wb_dst);
		if (src == 5'd0)
			pick = mips_pkg::fwd_own;
		else if (mem_en && mem_dst == src)
			pick = mips_pkg::fwd_mem;
		else if (wb_en && wb_dst == src)
			pick = mips_pkg::fwd_wb;
		else
			pick = mips_pkg::fwd_own;
	endfunction

	////////////////////
	// Stall

	// Source in decode matches a pending write ahead of it
	assign e_hit_rs = e_we && (d_rs != 5'd0) && (e_wreg == d_rs);
	assign e_hit_rt = e_we && (d_rt != 5'd0) && (e_wreg == d_rt);
	assign m_hit_rs = m_we && (d_rs != 5'd0) && (m_wreg == d_rs);
	assign m_hit_rt = m_we && (d_rt != 5'd0) && (m_wreg == d_rt);

	// Hold decode while the result shows up later than it is needed
	assign stall = (e_hit_rs && (e_t_new > t_use_rs))
		|| (e_hit_rt && (e_t_new > t_use_rt))
		|| (m_hit_rs && (m_t_new > t_use_rs))
		|| (m_hit_rt && (m_t_new > t_use_rt));

	////////////////////
	// Forwarding

	// Memory stage value exists only for ALU results
	// A load still in memory is left to the stall
	assign m_ready = m_we && (m_t_new == 2'd0);

	// Decode operands also feed the beq compare
	assign d_rs_sel = pick(d_rs, m_ready, m_wreg, w_we, w_wreg);
	assign d_rt_sel = pick(d_rt, m_ready, m_wreg, w_we, w_wreg);

	// Execute operands
	assign e_rs_sel = pick(e_rs, m_ready, m_wreg, w_we, w_wreg);
	assign e_rt_sel = pick(e_rt, m_ready, m_wreg, w_we, w_wreg);

	// Store data has only writeback older than it
	assign m_rt_sel = pick(m_rt, 1'b0, m_wreg, w_we, w_wreg);

endmodule

// ==== logic/instr_decode.sv ====
`timescale 1ns/1ns
module instr_decode (
	input logic [31:0] instr,
	output logic [4:0] rs,
	output logic [4:0] rt,
	output logic [4:0] wreg,
	output logic reg_we,
	output mips_pkg::alu_op_t alu_op,
	output logic [31:0] imm,
	output logic is_lw,
	output logic is_sw,
	output logic is_beq,
	output logic [1:0] t_use_rs,
	output logic [1:0] t_use_rt,
	output logic [1:0] t_new
);
	mips_pkg::instr_u iw;
	logic writes;

	assign iw = instr;

	// Source fields sit in the same place in both views
	assign rs = iw.i.rs;
	assign rt = iw.i.rt;

	always_comb begin
		// Defaults give a no-op that touches nothing
		wreg = 5'd0;
		writes = 1'b0;
		alu_op = mips_pkg::alu_add;
		imm = {{16{iw.i.imm16[15]}}, iw.i.imm16};
		is_lw = 1'b0;
		is_sw = 1'b0;
		is_beq = 1'b0;
		t_use_rs = mips_pkg::t_none;
		t_use_rt = mips_pkg::t_none;
		t_new = 2'd0;
		case (iw.r.op)
			mips_pkg::op_special: begin
				// Any funct other than addu and subu stays a no-op
				if (iw.r.funct == mips_pkg::fn_addu || iw.r.funct == mips_pkg::fn_subu) begin
					wreg = iw.r.rd;
					writes = 1'b1;
					if (iw.r.funct == mips_pkg::fn_subu)
						alu_op = mips_pkg::alu_sub;
					t_use_rs = mips_pkg::use_later;
					t_use_rt = mips_pkg::use_later;
					t_new = mips_pkg::new_alu_e;
				end
			end
			mips_pkg::op_ori: begin
				// Logical immediate is zero extended
				wreg = iw.i.rt;
				writes = 1'b1;
				alu_op = mips_pkg::alu_or;
				imm = {16'd0, iw.i.imm16};
				t_use_rs = mips_pkg::use_later;
				t_new = mips_pkg::new_alu_e;
			end
			mips_pkg::op_lw: begin
				wreg = iw.i.rt;
				writes = 1'b1;
				is_lw = 1'b1;
				t_use_rs = mips_pkg::use_later;
				t_new = mips_pkg::new_load_e;
			end
			mips_pkg::op_sw: begin
				// Store data is only needed at the memory stage
				is_sw = 1'b1;
				t_use_rs = mips_pkg::use_later;
				t_use_rt = mips_pkg::use_store;
			end
			mips_pkg::op_beq: begin
				// Compared in decode
				is_beq = 1'b1;
				t_use_rs = mips_pkg::use_now;
				t_use_rt = mips_pkg::use_now;
			end
			default: ;
		endcase
	end

	// r0 target is dropped here so nothing downstream sees it
	assign reg_we = writes && (wreg != 5'd0);

endmodule

// ==== logic/mips_pkg.sv ====
package mips_pkg;

	////////////////////
	// Opcodes and function codes
	localparam logic [5:0] op_special = 6'h00;
	localparam logic [5:0] op_ori = 6'h0d;
	localparam logic [5:0] op_lw = 6'h23;
	localparam logic [5:0] op_sw = 6'h2b;
	localparam logic [5:0] op_beq = 6'h04;

	// R format selected by op_special
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;

	////////////////////
	// Timing values
	// Use time is the stage that first needs the operand
	localparam logic [1:0] use_now = 2'd0;
	localparam logic [1:0] use_later = 2'd1;
	localparam logic [1:0] use_store = 2'd2;
	// Largest value so no new time can exceed it
	localparam logic [1:0] t_none = 2'd3;
	// New time as seen in execute and one less in memory
	localparam logic [1:0] new_alu_e = 2'd1;
	localparam logic [1:0] new_load_e = 2'd2;

	typedef enum logic [1:0] {
		alu_add = 2'd0,
		alu_sub = 2'd1,
		alu_or = 2'd2
	} alu_op_t;

	// Forwarding source per operand
	typedef enum logic [1:0] {
		fwd_own = 2'b00,
		fwd_mem = 2'b10,
		fwd_wb = 2'b11
	} fwd_sel_t;

	////////////////////
	// Instruction word in two views
	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm16;
	} i_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_u;

endpackage

// ==== logic/pipe_core.sv ====
`timescale 1ns/1ns
module pipe_core (
	input logic clk,
	input logic reset,
	output logic [29:0] pc,
	input logic [31:0] instr,
	output logic wb_valid,
	output logic [4:0] wb_reg,
	output logic [31:0] wb_data
);
	// Decode stage
	logic d_valid, d_go, stall, taken;
	logic [31:0] d_instr, qa, qb, d_a, d_b;
	logic [29:0] d_pc;
	logic [4:0] dc_rs, dc_rt, dc_wreg;
	logic dc_we, dc_is_lw, dc_is_sw, dc_is_beq;
	mips_pkg::alu_op_t dc_alu_op;
	logic [31:0] dc_imm;
	logic [1:0] dc_use_rs, dc_use_rt, dc_new, d_use_rs, d_use_rt;
	mips_pkg::fwd_sel_t d_rs_sel, d_rt_sel, e_rs_sel, e_rt_sel, m_rt_sel;
	// Execute stage
	logic e_we, e_is_lw, e_is_sw, e_use_rt;
	logic [1:0] e_t_new;
	logic [4:0] e_rs, e_rt, e_wreg;
	mips_pkg::alu_op_t e_alu_op;
	logic [31:0] e_imm, e_a, e_b, e_a_f, e_b_f, e_y;
	// Memory and writeback stages
	logic m_we, m_is_lw, m_is_sw;
	logic [1:0] m_t_new;
	logic [4:0] m_rt, m_wreg, w_wreg;
	logic [31:0] m_alu, m_sd, m_sd_f, m_ld, w_data;
	logic w_we;

	function automatic logic [31:0] fwd_mux(input mips_pkg::fwd_sel_t sel,
		input logic [31:0] own, input logic [31:0] mem_val, input logic [31:0] wb_val);
		case (sel)
			mips_pkg::fwd_mem: fwd_mux = mem_val;
			mips_pkg::fwd_wb: fwd_mux = wb_val;
			default: fwd_mux = own;
		endcase
	endfunction

	////////////////////
	// Decode
	instr_decode u_dec (.instr(d_instr), .rs(dc_rs), .rt(dc_rt), .wreg(dc_wreg), .reg_we(dc_we),
		.alu_op(dc_alu_op), .imm(dc_imm), .is_lw(dc_is_lw), .is_sw(dc_is_sw),
		.is_beq(dc_is_beq), .t_use_rs(dc_use_rs), .t_use_rt(dc_use_rt), .t_new(dc_new));

	// Empty decode slot needs nothing
	assign d_use_rs = d_valid ? dc_use_rs : mips_pkg::t_none;
	assign d_use_rt = d_valid ? dc_use_rt : mips_pkg::t_none;
	assign d_go = d_valid && !stall;

	hazard_unit u_haz (.d_rs(dc_rs), .d_rt(dc_rt), .t_use_rs(d_use_rs), .t_use_rt(d_use_rt),
		.e_wreg(e_wreg), .e_we(e_we), .e_t_new(e_t_new), .m_wreg(m_wreg), .m_we(m_we),
		.m_t_new(m_t_new), .w_wreg(w_wreg), .w_we(w_we), .e_rs(e_rs), .e_rt(e_rt), .m_rt(m_rt),
		.stall(stall), .d_rs_sel(d_rs_sel), .d_rt_sel(d_rt_sel), .e_rs_sel(e_rs_sel),
		.e_rt_sel(e_rt_sel), .m_rt_sel(m_rt_sel));

	reg_file u_rf (.clk(clk), .reset(reset), .ra(dc_rs), .rb(dc_rt), .qa(qa), .qb(qb),
		.wa(w_wreg), .we(w_we), .wd(w_data));

	assign d_a = fwd_mux(d_rs_sel, qa, m_alu, w_data);
	assign d_b = fwd_mux(d_rt_sel, qb, m_alu, w_data);
	// Delay slot is in fetch now and the target is relative to it
	assign taken = d_valid && dc_is_beq && (d_a == d_b);

	////////////////////
	// Execute and memory
	assign e_a_f = fwd_mux(e_rs_sel, e_a, m_alu, w_data);
	assign e_b_f = fwd_mux(e_rt_sel, e_b, m_alu, w_data);
	exec_alu u_alu (.alu_op(e_alu_op), .a(e_a_f), .b(e_use_rt ? e_b_f : e_imm), .y(e_y));

	assign m_sd_f = fwd_mux(m_rt_sel, m_sd, m_alu, w_data);
	data_ram u_ram (.clk(clk), .addr(m_alu), .we(m_is_sw), .wd(m_sd_f), .rd(m_ld));

	// r0 writes never reach the retire port
	assign wb_valid = w_we;
	assign wb_reg = w_wreg;
	assign wb_data = w_data;

	////////////////////
	// Control registers
	// A stall sends a bubble into execute
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= 30'd0;
			d_valid <= 1'b0;
			{e_we, e_is_lw, e_is_sw, e_t_new} <= '0;
			{m_we, m_is_lw, m_is_sw, m_t_new} <= '0;
			w_we <= 1'b0;
		end else begin
			if (!stall) begin
				pc <= taken ? (d_pc + 30'd1 + dc_imm[29:0]) : (pc + 30'd1);
				d_valid <= 1'b1;
			end
			e_we <= d_go && dc_we;
			e_is_lw <= d_go && dc_is_lw;
			e_is_sw <= d_go && dc_is_sw;
			e_t_new <= d_go ? dc_new : 2'd0;
			m_we <= e_we;
			m_is_lw <= e_is_lw;
			m_is_sw <= e_is_sw;
			// One cycle closer to the result
			m_t_new <= (e_t_new == 2'd0) ? 2'd0 : e_t_new - 2'd1;
			w_we <= m_we;
		end
	end

	// Payload registers
	always_ff @(posedge clk) begin
		if (!stall) begin
			d_instr <= instr;
			d_pc <= pc;
		end
		{e_rs, e_rt, e_wreg, e_imm} <= {dc_rs, dc_rt, dc_wreg, dc_imm};
		e_alu_op <= dc_alu_op;
		// Only R format takes rt into the ALU
		e_use_rt <= (dc_use_rt == mips_pkg::use_later);
		e_a <= d_a;
		e_b <= d_b;
		{m_rt, m_wreg, m_alu, m_sd} <= {e_rt, e_wreg, e_y, e_b_f};
		w_wreg <= m_wreg;
		w_data <= m_is_lw ? m_ld : m_alu;
	end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ns
module reg_file (
	input logic clk,
	input logic reset,
	input logic [4:0] ra,
	input logic [4:0] rb,
	output logic [31:0] qa,
	output logic [31:0] qb,
	input logic [4:0] wa,
	input logic we,
	input logic [31:0] wd
);
	logic [31:0] regs [0:31];
	logic wr_ok;

	// r0 is never written and stays at its reset zero
	assign wr_ok = we && (wa != 5'd0);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'd0;
		end else if (wr_ok) begin
			regs[wa] <= wd;
		end
	end

	// Write-through
	// Same-cycle read sees the value being written
	assign qa = (wr_ok && wa == ra) ? wd : regs[ra];
	assign qb = (wr_ok && wa == rb) ? wd : regs[rb];

endmodule

// ==== sim/pipe_core_tb.sv ====
`timescale 1ns/1ns
module pipe_core_tb;

	logic clk;
	logic reset;
	logic [29:0] pc;
	logic [31:0] instr;
	logic wb_valid;
	logic [4:0] wb_reg;
	logic [31:0] wb_data;

	// Instruction memory model and the expected retire list
	logic [31:0] imem [0:255];
	int plen;
	logic [4:0] exp_reg [0:255];
	logic [31:0] exp_data [0:255];
	int exp_n;
	int seen;
	string test_name;
	time deadline;

	pipe_core uut (.clk(clk), .reset(reset), .pc(pc), .instr(instr), .wb_valid(wb_valid),
		.wb_reg(wb_reg), .wb_data(wb_data));

	// Fetch answers in the same cycle
	assign instr = imem[pc[7:0]];

	always #50 clk = ~clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
			abort_run($sformatf("Error in %s, %s: expected %h, actual %h", test_name, what,
				exp, act));
	endtask

	function automatic logic [31:0] rfmt(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		rfmt = {mips_pkg::op_special, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] ifmt(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		ifmt = {op, rs, rt, imm};
	endfunction

	task automatic put(input logic [31:0] word);
		imem[plen] = word;
		plen++;
	endtask

	////////////////////
	// Instruction-level model, one instruction per step
	function automatic int run_model();
		logic [31:0] r [0:31];
		logic [31:0] m [0:63];
		logic [31:0] w, a, b, sx, addr, val;
		logic [4:0] dst;
		logic wr;
		int cur, pcm, npc, n;
		for (int i = 0; i < 32; i++)
			r[i] = 32'd0;
		pcm = 0;
		npc = 1;
		n = 0;
		while (pcm < plen) begin
			w = imem[pcm];
			a = r[w[25:21]];
			b = r[w[20:16]];
			sx = {{16{w[15]}}, w[15:0]};
			addr = a + sx;
			wr = 1'b0;
			dst = w[20:16];
			val = 32'd0;
			// Delay slot means the next fetch is already decided
			cur = pcm;
			pcm = npc;
			npc = npc + 1;
			case (w[31:26])
				mips_pkg::op_special: begin
					dst = w[15:11];
					wr = (w[5:0] == mips_pkg::fn_addu) || (w[5:0] == mips_pkg::fn_subu);
					val = (w[5:0] == mips_pkg::fn_subu) ? a - b : a + b;
				end
				mips_pkg::op_ori: begin
					wr = 1'b1;
					val = a | {16'd0, w[15:0]};
				end
				mips_pkg::op_lw: begin
					wr = 1'b1;
					val = m[addr[7:2]];
				end
				mips_pkg::op_sw: m[addr[7:2]] = b;
				mips_pkg::op_beq: if (a == b) npc = cur + 1 + int'($signed(sx));
				default: ;
			endcase
			// r0 absorbs writes and never retires
			if (wr && dst != 5'd0) begin
				r[dst] = val;
				exp_reg[n] = dst;
				exp_data[n] = val;
				n++;
			end
		end
		return n;
	endfunction

	////////////////////
	// Retire checker samples mid-cycle
	always @(negedge clk) begin
		if (!reset && wb_valid) begin
			if (seen >= exp_n) begin
				abort_run($sformatf("Test %s retired an extra write to r%0d", test_name, wb_reg));
			end else begin
				check("retire reg", {27'd0, exp_reg[seen]}, {27'd0, wb_reg});
				check("retire data", exp_data[seen], wb_data);
				seen++;
			end
		end
	end

	// Watchdog limit follows the program length
	always @(negedge clk) begin
		if (!reset && $time > deadline)
			abort_run($sformatf("Retirement stalled in test %s after %0d of %0d writes",
				test_name, seen, exp_n));
	end

	// Reset goes up first so a new program is never fetched early
	task automatic clear_prog();
		@(posedge clk);
		#1 reset = 1'b1;
		for (int i = 0; i < 256; i++)
			imem[i] = 32'd0;
		plen = 0;
	endtask

	task automatic run_test(input string name);
		test_name = name;
		exp_n = run_model();
		seen = 0;
		repeat (2) @(posedge clk);
		deadline = $time + 100 * (20 * plen + 10);
		#1 reset = 1'b0;
		check("pc after reset", 32'd0, {2'd0, pc});
		check("wb_valid after reset", 32'd0, {31'd0, wb_valid});
		wait (seen == exp_n);
		// Whole program fetched and drained so a late stray write still shows up
		wait (pc >= plen);
		repeat (6) @(posedge clk);
	endtask

	// Straight line mix on r0..r7 with loads only from stored words
	task automatic random_prog();
		logic [31:0] r32;
		logic [7:0] stored;
		logic [4:0] d, s, t;
		logic [15:0] off;
		stored = 8'd0;
		for (int i = 0; i < 20; i++) begin
			r32 = $urandom;
			d = {2'd0, r32[2:0]};
			s = {2'd0, r32[5:3]};
			t = {2'd0, r32[8:6]};
			off = {11'd0, r32[11:9], 2'd0};
			case (r32[31:29])
				3'd0, 3'd1: put(rfmt(mips_pkg::fn_addu, s, t, d));
				3'd2: put(rfmt(mips_pkg::fn_subu, s, t, d));
				3'd3, 3'd4: put(ifmt(mips_pkg::op_ori, s, d, r32[27:12]));
				3'd5: begin
					if (stored[r32[11:9]])
						put(ifmt(mips_pkg::op_lw, 5'd0, d, off));
					else
						put(ifmt(mips_pkg::op_sw, 5'd0, t, off));
					stored[r32[11:9]] = 1'b1;
				end
				default: begin
					put(ifmt(mips_pkg::op_sw, 5'd0, t, off));
					stored[r32[11:9]] = 1'b1;
				end
			endcase
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		plen = 0;
		seen = 0;
		exp_n = 0;
		deadline = 0;
		test_name = "startup";
		void'($urandom(3589));

		// Dependent ALU chain with mem and wb forwarding into execute
		clear_prog();
		put(ifmt(mips_pkg::op_ori, 5'd0, 5'd1, 16'h1234));
		put(ifmt(mips_pkg::op_ori, 5'd0, 5'd2, 16'hf0f0));
		put(rfmt(mips_pkg::fn_addu, 5'd1, 5'd2, 5'd3));
		put(rfmt(mips_pkg::fn_subu, 5'd3, 5'd1, 5'd4));
		put(rfmt(mips_pkg::fn_addu, 5'd4, 5'd3, 5'd5));
		put(ifmt(mips_pkg::op_ori, 5'd5, 5'd6, 16'hff00));
		put(rfmt(mips_pkg::fn_subu, 5'd6, 5'd7, 5'd7));
		put(rfmt(mips_pkg::fn_addu, 5'd1, 5'd1, 5'd1));
		run_test("alu_chain");

		// Store then load, load-use stall, load into store data
		clear_prog();
		put(ifmt(mips_pkg::op_ori, 5'd0, 5'd1, 16'habcd));
		put(ifmt(mips_pkg::op_sw, 5'd0, 5'd1, 16'd8));
		put(ifmt(mips_pkg::op_lw, 5'd0, 5'd2, 16'd8));
		put(rfmt(mips_pkg::fn_addu, 5'd2, 5'd1, 5'd3));
		put(ifmt(mips_pkg::op_lw, 5'd0, 5'd4, 16'd8));
		put(ifmt(mips_pkg::op_sw, 5'd0, 5'd4, 16'd12));
		put(ifmt(mips_pkg::op_lw, 5'd0, 5'd5, 16'd12));
		put(rfmt(mips_pkg::fn_subu, 5'd5, 5'd3, 5'd6));
		// Base register produced just before
		put(ifmt(mips_pkg::op_ori, 5'd0, 5'd7, 16'd16));
		put(ifmt(mips_pkg::op_sw, 5'd7, 5'd6, 16'd0));
		put(ifmt(mips_pkg::op_lw, 5'd0, 5'd8, 16'd16));
		run_test("load_store");

		// beq taken, not taken after a load, taken on a fresh ALU result
		clear_prog();
		put(ifmt(mips_pkg::op_ori, 5'd0, 5'd1, 16'd5));
		put(ifmt(mips_pkg::op_ori, 5'd0, 5'd2, 16'd5));
		put(ifmt(mips_pkg::op_beq, 5'd1, 5'd2, 16'd2));
		put(ifmt(mips_pkg::op_ori, 5'd0, 5'd3, 16'd1));
		put(ifmt(mips_pkg::op_ori, 5'd0, 5'd4, 16'd2));
		put(ifmt(mips_pkg::op_ori, 5'd0, 5'd5, 16'd3));
		put(ifmt(mips_pkg::op_sw, 5'd0, 5'd5, 16'd0));
		put(ifmt(mips_pkg::op_lw, 5'd0, 5'd6, 16'd0));
		put(ifmt(mips_pkg::op_beq, 5'd6, 5'd1, 16'd1));
		put(ifmt(mips_pkg::op_ori, 5'd0, 5'd7, 16'd4));
		put(ifmt(mips_pkg::op_ori, 5'd0, 5'd8, 16'd6));
		put(rfmt(mips_pkg::fn_subu, 5'd5, 5'd5, 5'd9));
		put(ifmt(mips_pkg::op_beq, 5'd9, 5'd0, 16'd2));
		put(rfmt(mips_pkg::fn_addu, 5'd1, 5'd2, 5'd10));
		put(ifmt(mips_pkg::op_ori, 5'd0, 5'd11, 16'd8));
		put(ifmt(mips_pkg::op_ori, 5'd0, 5'd12, 16'd7));
		run_test("branch");

		// r0 targets stay off the retire port and read back as zero
		clear_prog();
		put(ifmt(mips_pkg::op_ori, 5'd0, 5'd0, 16'h0055));
		put(rfmt(mips_pkg::fn_addu, 5'd0, 5'd0, 5'd1));
		put(ifmt(mips_pkg::op_ori, 5'd0, 5'd2, 16'd9));
		put(rfmt(mips_pkg::fn_subu, 5'd2, 5'd0, 5'd0));
		put(rfmt(mips_pkg::fn_addu, 5'd0, 5'd2, 5'd3));
		run_test("reg_zero");

		for (int p = 0; p < 40; p++) begin
			clear_prog();
			random_prog();
			run_test($sformatf("random_%0d", p));
		end

		$display("RESULT: PASS");
		$finish;
	end

endmodule
